//--- verilog/alu_pkg.sv
package alu_pkg;

  // datapath width fixed by the word forms
  localparam int xlen = 64;

  typedef enum logic [4:0] {
    add, sub, sll, slt, sltu, xor_op, srl, sra, or_op, and_op, pass2,
    mul, mulh, mulhsu, mulhu, div, divu, rem, remu
  } alu_op_t;

  typedef struct packed {
    logic            valid;
    alu_op_t         op;
    logic            word;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
  } alu_req_t;

  typedef enum logic [1:0] {
    unit_int,
    unit_mul,
    unit_div
  } unit_sel_t;

  // integer output select codes
  localparam logic [2:0] out_add   = 3'd0;
  localparam logic [2:0] out_shift = 3'd1;
  localparam logic [2:0] out_less  = 3'd2;
  localparam logic [2:0] out_src2  = 3'd3;
  localparam logic [2:0] out_xor   = 3'd4;
  localparam logic [2:0] out_or    = 3'd6;
  localparam logic [2:0] out_and   = 3'd7;

  typedef struct packed {
    logic       sub;
    logic       cmp_unsigned;
    logic       shift_right;
    logic       shift_arith;
    logic       word;
    logic [2:0] out_sel;
  } int_ctl_t;

  typedef struct packed {
    logic high;
    logic src1_signed;
    logic src2_signed;
  } mul_ctl_t;

  typedef struct packed {
    logic is_signed;
    logic want_rem;
  } div_ctl_t;

  typedef struct packed {
    unit_sel_t unit;
    logic      word;
    int_ctl_t  int_ctl;
    mul_ctl_t  mul_ctl;
    div_ctl_t  div_ctl;
  } exec_ctl_t;

endpackage

//--- verilog/alu_decode.sv
`timescale 1ns/100ps

module alu_decode (
  input  alu_pkg::alu_req_t         req,
  input  logic                      mul_busy,
  input  logic                      mul_done,
  input  logic                      div_busy,
  input  logic                      div_done,
  output alu_pkg::exec_ctl_t        ctl,
  output logic [alu_pkg::xlen-1:0]  opa,
  output logic [alu_pkg::xlen-1:0]  opb,
  output logic                      mul_start,
  output logic                      div_start
);

  logic div_word;

  always_comb begin
    ctl = '0;
    ctl.unit = alu_pkg::unit_int;
    ctl.word = req.word;
    ctl.int_ctl.word = req.word;
    case (req.op)
      alu_pkg::add:    ctl.int_ctl.out_sel = alu_pkg::out_add;
      alu_pkg::sub: begin
        ctl.int_ctl.sub = 1'b1;
        ctl.int_ctl.out_sel = alu_pkg::out_add;
      end
      alu_pkg::sll:    ctl.int_ctl.out_sel = alu_pkg::out_shift;
      alu_pkg::slt, alu_pkg::sltu: begin
        // compare is a subtract and less comes from carry or overflow
        ctl.int_ctl.sub = 1'b1;
        ctl.int_ctl.cmp_unsigned = (req.op == alu_pkg::sltu);
        ctl.int_ctl.out_sel = alu_pkg::out_less;
      end
      alu_pkg::xor_op: ctl.int_ctl.out_sel = alu_pkg::out_xor;
      alu_pkg::srl, alu_pkg::sra: begin
        ctl.int_ctl.shift_right = 1'b1;
        ctl.int_ctl.shift_arith = (req.op == alu_pkg::sra);
        ctl.int_ctl.out_sel = alu_pkg::out_shift;
      end
      alu_pkg::or_op:  ctl.int_ctl.out_sel = alu_pkg::out_or;
      alu_pkg::and_op: ctl.int_ctl.out_sel = alu_pkg::out_and;
      alu_pkg::pass2:  ctl.int_ctl.out_sel = alu_pkg::out_src2;
      alu_pkg::mul, alu_pkg::mulh, alu_pkg::mulhsu, alu_pkg::mulhu: begin
        ctl.unit = alu_pkg::unit_mul;
        ctl.mul_ctl.high = (req.op != alu_pkg::mul);
        ctl.mul_ctl.src1_signed = (req.op == alu_pkg::mulh) || (req.op == alu_pkg::mulhsu);
        ctl.mul_ctl.src2_signed = (req.op == alu_pkg::mulh);
      end
      alu_pkg::div, alu_pkg::divu, alu_pkg::rem, alu_pkg::remu: begin
        ctl.unit = alu_pkg::unit_div;
        ctl.div_ctl.is_signed = (req.op == alu_pkg::div) || (req.op == alu_pkg::rem);
        ctl.div_ctl.want_rem = (req.op == alu_pkg::rem) || (req.op == alu_pkg::remu);
      end
      default: ctl.int_ctl.out_sel = alu_pkg::out_add;
    endcase
  end

  // word divides work on the low half, extended to full width
  assign div_word = req.word & (ctl.unit == alu_pkg::unit_div);

  always_comb begin
    opa = req.src1;
    opb = req.src2;
    if (div_word) begin
      opa = {{(alu_pkg::xlen-32){ctl.div_ctl.is_signed & req.src1[31]}}, req.src1[31:0]};
      opb = {{(alu_pkg::xlen-32){ctl.div_ctl.is_signed & req.src2[31]}}, req.src2[31:0]};
    end
  end

  // a unit starts once per request, not while running or holding a result
  assign mul_start = req.valid & (ctl.unit == alu_pkg::unit_mul) & ~mul_busy & ~mul_done;
  assign div_start = req.valid & (ctl.unit == alu_pkg::unit_div) & ~div_busy & ~div_done;

endmodule

//--- verilog/int_alu.sv
`timescale 1ns/100ps

module int_alu (
  input  alu_pkg::int_ctl_t         ctl,
  input  logic [alu_pkg::xlen-1:0]  src1,
  input  logic [alu_pkg::xlen-1:0]  src2,
  output logic [alu_pkg::xlen-1:0]  res
);

  logic [alu_pkg::xlen-1:0] opb_inv;
  logic [alu_pkg::xlen:0]   sum;
  logic [alu_pkg::xlen-1:0] add_res;
  logic                     carry;
  logic                     overflow;
  logic                     less;
  logic [5:0]               shamt;
  logic [alu_pkg::xlen-1:0] sh_src;
  logic [alu_pkg::xlen-1:0] sh_in;
  logic [alu_pkg::xlen-1:0] sh_out;
  logic [alu_pkg::xlen-1:0] fill_mask;
  logic                     fill;
  logic [alu_pkg::xlen-1:0] shift_res;

  function automatic logic [alu_pkg::xlen-1:0] bit_rev(input logic [alu_pkg::xlen-1:0] v);
    logic [alu_pkg::xlen-1:0] r;
    for (int i = 0; i < alu_pkg::xlen; i++) begin
      r[i] = v[alu_pkg::xlen-1-i];
    end
    return r;
  endfunction

  // single adder that subtracts by inverting src2 with carry in
  assign opb_inv = src2 ^ {alu_pkg::xlen{ctl.sub}};
  assign sum = {1'b0, src1} + {1'b0, opb_inv} + {{alu_pkg::xlen{1'b0}}, ctl.sub};
  assign add_res = sum[alu_pkg::xlen-1:0];
  assign carry = sum[alu_pkg::xlen];
  assign overflow = (src1[alu_pkg::xlen-1] == opb_inv[alu_pkg::xlen-1]) &&
                    (add_res[alu_pkg::xlen-1] != src1[alu_pkg::xlen-1]);
  assign less = ctl.cmp_unsigned ? ~carry : add_res[alu_pkg::xlen-1] ^ overflow;

  // word shifts only see the low half; sraw fills from bit 31
  assign shamt = ctl.word ? {1'b0, src2[4:0]} : src2[5:0];
  assign sh_src = ctl.word ?
                  {{(alu_pkg::xlen-32){ctl.shift_arith & src1[31]}}, src1[31:0]} : src1;

  // left shift = reverse, shift right, reverse back
  assign sh_in = ctl.shift_right ? sh_src : bit_rev(sh_src);
  assign sh_out = sh_in >> shamt;
  assign fill = ctl.shift_right & ctl.shift_arith & sh_src[alu_pkg::xlen-1];
  assign fill_mask = ~({alu_pkg::xlen{1'b1}} >> shamt);
  assign shift_res = ctl.shift_right ? (sh_out | (fill_mask & {alu_pkg::xlen{fill}})) :
                     bit_rev(sh_out);

  always_comb begin
    case (ctl.out_sel)
      alu_pkg::out_shift: res = shift_res;
      alu_pkg::out_less:  res = {{(alu_pkg::xlen-1){1'b0}}, less};
      alu_pkg::out_src2:  res = src2;
      alu_pkg::out_xor:   res = src1 ^ src2;
      alu_pkg::out_or:    res = src1 | src2;
      alu_pkg::out_and:   res = src1 & src2;
      default:            res = add_res;
    endcase
  end

endmodule

//--- verilog/mul_unit.sv
`timescale 1ns/100ps

module mul_unit (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic                      flush,
  input  alu_pkg::mul_ctl_t         ctl,
  input  logic [alu_pkg::xlen-1:0]  src1,
  input  logic [alu_pkg::xlen-1:0]  src2,
  output logic                      busy,
  output logic                      done,
  output logic [alu_pkg::xlen-1:0]  res
);

  logic [alu_pkg::xlen+1:0]             a_ext;
  logic [alu_pkg::xlen+1:0]             b_ext;
  logic [2*alu_pkg::xlen-1:0]           acc;
  logic [2*alu_pkg::xlen-1:0]           mcand;
  logic [2*alu_pkg::xlen-1:0]           pp;
  logic [alu_pkg::xlen+1:0]             mplier;
  logic [$clog2(alu_pkg::xlen/4)-1:0]   cnt;
  logic                                 top_neg;

  assign a_ext = {{2{ctl.src1_signed & src1[alu_pkg::xlen-1]}}, src1};
  assign b_ext = {{2{ctl.src2_signed & src2[alu_pkg::xlen-1]}}, src2};

  // top digit has negative weight on bit 3 for a signed multiplier
  assign top_neg = (&cnt) & mplier[alu_pkg::xlen+1];

  // partial product of one 4-bit digit
  always_comb begin
    pp = '0;
    for (int i = 0; i < 3; i++) begin
      if (mplier[i]) begin
        pp = pp + (mcand << i);
      end
    end
    if (mplier[3]) begin
      pp = top_neg ? pp - (mcand << 3) : pp + (mcand << 3);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt <= '0;
    end else if (flush) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else if (done) begin
      // result consumed this cycle
      done <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
      cnt <= '0;
    end else if (busy) begin
      cnt <= cnt + 1'b1;
      if (&cnt) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      acc <= '0;
      mcand <= {{(alu_pkg::xlen-2){a_ext[alu_pkg::xlen+1]}}, a_ext};
      mplier <= b_ext;
    end else if (busy) begin
      acc <= acc + pp;
      mcand <= mcand << 4;
      mplier <= {{4{mplier[alu_pkg::xlen+1]}}, mplier[alu_pkg::xlen+1:4]};
    end
  end

  assign res = ctl.high ? acc[2*alu_pkg::xlen-1:alu_pkg::xlen] : acc[alu_pkg::xlen-1:0];

endmodule

//--- verilog/div_unit.sv
`timescale 1ns/100ps

module div_unit (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic                      flush,
  input  alu_pkg::div_ctl_t         ctl,
  input  logic [alu_pkg::xlen-1:0]  src1,
  input  logic [alu_pkg::xlen-1:0]  src2,
  output logic                      busy,
  output logic                      done,
  output logic [alu_pkg::xlen-1:0]  res
);

  logic [alu_pkg::xlen-1:0]           quo;
  logic [alu_pkg::xlen-1:0]           rmd;
  logic [alu_pkg::xlen-1:0]           dvsr;
  logic [$clog2(alu_pkg::xlen)-1:0]   cnt;
  logic                               a_neg;
  logic                               b_neg;
  logic                               q_neg;
  logic                               r_neg;
  logic [alu_pkg::xlen:0]             shifted;
  logic [alu_pkg::xlen+1:0]           diff;

  assign a_neg = ctl.is_signed & src1[alu_pkg::xlen-1];
  assign b_neg = ctl.is_signed & src2[alu_pkg::xlen-1];

  // each restoring step shifts in the next dividend bit and tries the subtract
  assign shifted = {rmd, quo[alu_pkg::xlen-1]};
  assign diff = {1'b0, shifted} - {2'b0, dvsr};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt <= '0;
    end else if (flush) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else if (done) begin
      done <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
      cnt <= '0;
    end else if (busy) begin
      cnt <= cnt + 1'b1;
      if (&cnt) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      quo <= a_neg ? -src1 : src1;
      dvsr <= b_neg ? -src2 : src2;
      rmd <= '0;
      // zero divisor leaves the all-ones quotient unsigned
      q_neg <= (a_neg ^ b_neg) & (|src2);
      r_neg <= a_neg;
    end else if (busy) begin
      if (!diff[alu_pkg::xlen+1]) begin
        rmd <= diff[alu_pkg::xlen-1:0];
        quo <= {quo[alu_pkg::xlen-2:0], 1'b1};
      end else begin
        rmd <= shifted[alu_pkg::xlen-1:0];
        quo <= {quo[alu_pkg::xlen-2:0], 1'b0};
      end
    end
  end

  // with divisor 0 the steps give quotient all ones, remainder the dividend;
  // min / -1 gives quotient 2^63 which negates back to the dividend, rem 0
  always_comb begin
    if (ctl.want_rem) begin
      res = r_neg ? -rmd : rmd;
    end else begin
      res = q_neg ? -quo : quo;
    end
  end

endmodule

//--- verilog/alu_result.sv
`timescale 1ns/100ps

module alu_result (
  input  logic                      req_valid,
  input  alu_pkg::exec_ctl_t        ctl,
  input  logic [alu_pkg::xlen-1:0]  int_res,
  input  logic [alu_pkg::xlen-1:0]  mul_res,
  input  logic [alu_pkg::xlen-1:0]  div_res,
  input  logic                      mul_done,
  input  logic                      div_done,
  output logic [alu_pkg::xlen-1:0]  res,
  output logic                      stall
);

  logic [alu_pkg::xlen-1:0] sel_res;

  always_comb begin
    case (ctl.unit)
      alu_pkg::unit_mul: sel_res = mul_res;
      alu_pkg::unit_div: sel_res = div_res;
      default:           sel_res = int_res;
    endcase
  end

  // word results are sign-extended from bit 31
  assign res = ctl.word ? {{(alu_pkg::xlen-32){sel_res[31]}}, sel_res[31:0]} : sel_res;

  // hold the caller until the iterative unit has its result
  assign stall = req_valid &
                 (((ctl.unit == alu_pkg::unit_mul) & ~mul_done) |
                  ((ctl.unit == alu_pkg::unit_div) & ~div_done));

endmodule

//--- verilog/alu_top.sv
`timescale 1ns/100ps

module alu_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  alu_pkg::alu_req_t         req,
  input  logic                      flush,
  output logic [alu_pkg::xlen-1:0]  res,
  output logic                      stall
);

  alu_pkg::exec_ctl_t        ctl;
  logic [alu_pkg::xlen-1:0]  opa;
  logic [alu_pkg::xlen-1:0]  opb;
  logic                      mul_start;
  logic                      mul_busy;
  logic                      mul_done;
  logic [alu_pkg::xlen-1:0]  mul_res;
  logic                      div_start;
  logic                      div_busy;
  logic                      div_done;
  logic [alu_pkg::xlen-1:0]  div_res;
  logic [alu_pkg::xlen-1:0]  int_res;

  alu_decode i_decode (
    .req       (req),
    .mul_busy  (mul_busy),
    .mul_done  (mul_done),
    .div_busy  (div_busy),
    .div_done  (div_done),
    .ctl       (ctl),
    .opa       (opa),
    .opb       (opb),
    .mul_start (mul_start),
    .div_start (div_start)
  );

  int_alu i_int_alu (
    .ctl  (ctl.int_ctl),
    .src1 (opa),
    .src2 (opb),
    .res  (int_res)
  );

  mul_unit i_mul (
    .clk   (clk),
    .rst_n (rst_n),
    .start (mul_start),
    .flush (flush),
    .ctl   (ctl.mul_ctl),
    .src1  (opa),
    .src2  (opb),
    .busy  (mul_busy),
    .done  (mul_done),
    .res   (mul_res)
  );

  div_unit i_div (
    .clk   (clk),
    .rst_n (rst_n),
    .start (div_start),
    .flush (flush),
    .ctl   (ctl.div_ctl),
    .src1  (opa),
    .src2  (opb),
    .busy  (div_busy),
    .done  (div_done),
    .res   (div_res)
  );

  alu_result i_result (
    .req_valid (req.valid),
    .ctl       (ctl),
    .int_res   (int_res),
    .mul_res   (mul_res),
    .div_res   (div_res),
    .mul_done  (mul_done),
    .div_done  (div_done),
    .res       (res),
    .stall     (stall)
  );

endmodule

//--- verif/tb_top.sv
`timescale 1ns/100ps

module tb_top;

  localparam int n_int = 300;
  localparam int n_muldiv = 150;
  // divides take about 67 cycles each, multiplies about 19
  localparam int timeout_cycles = 20 + n_int * 2 + n_muldiv * 80 + 200;
  localparam logic [63:0] min64 = 64'h8000_0000_0000_0000;

  logic              clk;
  logic              rst_n;
  logic              flush;
  alu_pkg::alu_req_t req;
  logic [63:0]       res;
  logic              stall;
  logic [31:0]       lfsr;
  int                cycles;

  alu_top i_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .flush (flush),
    .res   (res),
    .stall (stall)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == timeout_cycles) begin
      $display("run timed out after %0d cycles", cycles);
      $display("TEST FAIL");
      $fatal(1, "timeout");
    end
  end

  // galois lfsr stepped once per random bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  // mostly random with an occasional 0, -1 or most negative value
  function automatic logic [63:0] rand_operand();
    logic [63:0] r;
    if (rand_bits(3) == 0) begin
      case (rand_bits(2))
        0:       r = '0;
        1:       r = '1;
        default: r = min64;
      endcase
    end else begin
      r = rand_bits(64);
    end
    return r;
  endfunction

  function automatic logic word_ok(input alu_pkg::alu_op_t op);
    return op inside {alu_pkg::add, alu_pkg::sub, alu_pkg::sll, alu_pkg::srl, alu_pkg::sra,
                      alu_pkg::mul, alu_pkg::div, alu_pkg::divu, alu_pkg::rem, alu_pkg::remu};
  endfunction

  // reference model in 128-bit arithmetic with the RISC-V division rules
  function automatic logic [63:0] model(input alu_pkg::alu_op_t op, input logic word,
                                        input logic [63:0] a, input logic [63:0] b);
    logic [127:0]        ua;
    logic [127:0]        ub;
    logic signed [127:0] sa;
    logic signed [127:0] sb;
    logic signed [127:0] q;
    logic [127:0]        prod;
    logic [31:0]         w;
    logic [63:0]         r;
    if (word && op inside {alu_pkg::div, alu_pkg::rem}) begin
      a = {{32{a[31]}}, a[31:0]};
      b = {{32{b[31]}}, b[31:0]};
    end else if (word && op inside {alu_pkg::divu, alu_pkg::remu}) begin
      a = {32'b0, a[31:0]};
      b = {32'b0, b[31:0]};
    end
    ua = {64'b0, a};
    ub = {64'b0, b};
    sa = {{64{a[63]}}, a};
    sb = {{64{b[63]}}, b};
    case (op)
      alu_pkg::add:    r = a + b;
      alu_pkg::sub:    r = a - b;
      alu_pkg::sll: begin
        w = a[31:0] << b[4:0];
        r = word ? {32'b0, w} : a << b[5:0];
      end
      alu_pkg::slt:    r = {63'b0, $signed(a) < $signed(b)};
      alu_pkg::sltu:   r = {63'b0, a < b};
      alu_pkg::xor_op: r = a ^ b;
      alu_pkg::srl: begin
        w = a[31:0] >> b[4:0];
        r = word ? {32'b0, w} : a >> b[5:0];
      end
      alu_pkg::sra: begin
        w = $signed(a[31:0]) >>> b[4:0];
        if (word) begin
          r = {32'b0, w};
        end else begin
          r = $signed(a) >>> b[5:0];
        end
      end
      alu_pkg::or_op:  r = a | b;
      alu_pkg::and_op: r = a & b;
      alu_pkg::pass2:  r = b;
      alu_pkg::mul: begin
        prod = ua * ub;
        r = prod[63:0];
      end
      alu_pkg::mulh: begin
        prod = sa * sb;
        r = prod[127:64];
      end
      alu_pkg::mulhsu: begin
        prod = sa * ub;
        r = prod[127:64];
      end
      alu_pkg::mulhu: begin
        prod = ua * ub;
        r = prod[127:64];
      end
      alu_pkg::div: begin
        q = sa / sb;
        r = (b == 0) ? '1 : q[63:0];
      end
      alu_pkg::divu:   r = (b == 0) ? '1 : a / b;
      alu_pkg::rem: begin
        q = sa % sb;
        r = (b == 0) ? a : q[63:0];
      end
      alu_pkg::remu:   r = (b == 0) ? a : a % b;
      default:         r = '0;
    endcase
    if (word) begin
      r = {{32{r[31]}}, r[31:0]};
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // entered 1 ns after a rising edge; holds req until stall falls
  task automatic run_op(input alu_pkg::alu_op_t op, input logic word,
                        input logic [63:0] a, input logic [63:0] b, input string name);
    logic [63:0] exp;
    logic        iter;
    exp = model(op, word, a, b);
    iter = (op >= alu_pkg::mul);
    req.valid = 1'b1;
    req.op = op;
    req.word = word;
    req.src1 = a;
    req.src2 = b;
    @(negedge clk);
    check({name, " stall"}, {63'b0, iter}, {63'b0, stall});
    while (stall) begin
      @(negedge clk);
    end
    check(name, exp, res);
    @(posedge clk);
    #1;
  endtask

  initial begin
    alu_pkg::alu_op_t op;
    logic             word;
    lfsr = 32'hfc72;
    cycles = 0;
    rst_n = 1'b0;
    flush = 1'b0;
    req = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check("stall after reset", 64'd0, {63'b0, stall});
    @(posedge clk);
    #1;

    for (int i = 0; i < n_int; i++) begin
      op = alu_pkg::alu_op_t'(5'(rand_bits(4) % 11));
      word = (rand_bits(1) != 0) & word_ok(op);
      run_op(op, word, rand_operand(), rand_operand(), $sformatf("int op %0d", i));
    end

    for (int i = 0; i < n_muldiv; i++) begin
      op = alu_pkg::alu_op_t'(5'd11 + 5'(rand_bits(3)));
      word = (rand_bits(1) != 0) & word_ok(op);
      run_op(op, word, rand_operand(), rand_operand(), $sformatf("muldiv op %0d", i));
    end

    // division corner cases
    run_op(alu_pkg::div, 1'b0, min64, '1, "div overflow");
    run_op(alu_pkg::rem, 1'b0, min64, '1, "rem overflow");
    run_op(alu_pkg::div, 1'b0, 64'h1234, '0, "div by zero");
    run_op(alu_pkg::remu, 1'b0, 64'hdead_beef, '0, "remu by zero");
    run_op(alu_pkg::div, 1'b1, 64'h8000_0000, 64'hffff_ffff, "divw overflow");
    run_op(alu_pkg::rem, 1'b1, 64'h8000_0000, 64'hffff_ffff, "remw overflow");
    run_op(alu_pkg::divu, 1'b1, 64'h55_8765_4321, '0, "divuw by zero");
    run_op(alu_pkg::rem, 1'b1, 64'h9abc_def0, 64'hf_0000_0000, "remw by zero");

    // identical requests back to back each run once
    run_op(alu_pkg::mulh, 1'b0, 64'hfedc_ba98_7654_3210, 64'h0123_4567_89ab_cdef, "mul b2b 1");
    run_op(alu_pkg::mulh, 1'b0, 64'hfedc_ba98_7654_3210, 64'h0123_4567_89ab_cdef, "mul b2b 2");

    // flush a divide in flight, then run a different multiply and a divide
    req.valid = 1'b1;
    req.op = alu_pkg::div;
    req.word = 1'b0;
    req.src1 = 64'h7777_0000_1111;
    req.src2 = 64'h33;
    repeat (5) @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    run_op(alu_pkg::mul, 1'b0, 64'h1_0000_0003, 64'hffff_fff5, "mul after flush");
    run_op(alu_pkg::divu, 1'b0, 64'hffff_0000_0000_0001, 64'h7, "div after flush");

    // reset in the middle of a multiply
    req.op = alu_pkg::mulhu;
    req.src1 = '1;
    req.src2 = '1;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b0;
    req.valid = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check("stall after second reset", 64'd0, {63'b0, stall});
    @(posedge clk);
    #1;
    run_op(alu_pkg::mulhsu, 1'b0, min64, '1, "mul after reset");

    $display("TEST PASS");
    $finish;
  end

endmodule

//--- flist.f
verilog/alu_pkg.sv
verilog/alu_decode.sv
verilog/int_alu.sv
verilog/mul_unit.sv
verilog/div_unit.sv
verilog/alu_result.sv
verilog/alu_top.sv
verif/tb_top.sv

//--- run.sh
#!/bin/bash
# build and run the execute stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_top -f flist.f; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_top > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TEST PASS" sim.log; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1
